// File: hw/bpu_macros.svh
`ifndef BPU_MACROS_SVH
`define BPU_MACROS_SVH

// Data and address width.
`define BPU_XLEN 32

// PC after reset.
`define BPU_RESET_VECTOR 32'h8000_0000

// Sequential fetch increment, one 32-bit instruction.
`define BPU_INSTR_STEP 32'd4

// Full SYSTEM words, matched exactly by the decoder.
`define BPU_ECALL_WORD 32'h0000_0073
`define BPU_MRET_WORD  32'h3020_0073

`endif

// File: hw/bpu_pkg.sv
`include "bpu_macros.svh"

package bpu_pkg;

  typedef logic [`BPU_XLEN-1:0] xlen_t;  // Register or CSR word.
  typedef logic [`BPU_XLEN-1:0] addr_t;  // Instruction address.
  typedef logic [31:0]          instr_t;

  // Control-flow operation of the current instruction.
  typedef enum logic [3:0] {
    BPU_NONE,
    BPU_BEQ,
    BPU_BNE,
    BPU_BLT,
    BPU_BGE,
    BPU_BLTU,
    BPU_BGEU,
    BPU_JAL,
    BPU_JALR
  } bpu_op_e;

  // Trap entry and return.
  typedef enum logic [1:0] {
    CSR_NONE,
    CSR_ECALL,
    CSR_MRET
  } csr_op_e;

  // Decoder output.
  typedef struct packed {
    bpu_op_e bpu_op;
    csr_op_e csr_op;
    xlen_t   imm;
  } branch_ctrl_t;

  typedef struct packed {
    logic eq;
    logic lt;   // Signed.
    logic ltu;  // Unsigned.
  } cmp_flags_t;

  // Candidate next addresses.
  typedef struct packed {
    addr_t pc_rel;   // pc + imm.
    addr_t reg_rel;  // (rdata1 + imm) with bit 0 cleared.
    addr_t seq;      // pc + 4.
  } targets_t;

endpackage

// File: hw/branch_decode.sv
`timescale 1ns/1ps
`include "bpu_macros.svh"

module branch_decode (
  input  bpu_pkg::instr_t       instr_i,
  output bpu_pkg::branch_ctrl_t ctrl_o
);

  import bpu_pkg::*;

  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  logic [6:0] opcode;
  logic [2:0] funct3;
  xlen_t      imm_btype;
  xlen_t      imm_jtype;
  xlen_t      imm_itype;
  bpu_op_e    cond_op;
  csr_op_e    trap_op;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];

  // Immediates sign-extended from bit 31.
  assign imm_btype = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                      instr_i[11:8], 1'b0};
  assign imm_jtype = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                      instr_i[30:21], 1'b0};
  assign imm_itype = {{20{instr_i[31]}}, instr_i[31:20]};

  // Condition from funct3 of a BRANCH word.
  always_comb begin
    case (funct3)
      3'b000:  cond_op = BPU_BEQ;
      3'b001:  cond_op = BPU_BNE;
      3'b100:  cond_op = BPU_BLT;
      3'b101:  cond_op = BPU_BGE;
      3'b110:  cond_op = BPU_BLTU;
      3'b111:  cond_op = BPU_BGEU;
      default: cond_op = BPU_NONE;  // 010 and 011 are reserved.
    endcase
  end

  // Whole-word match for the trap words.
  always_comb begin
    if (instr_i == `BPU_ECALL_WORD) begin
      trap_op = CSR_ECALL;
    end else if (instr_i == `BPU_MRET_WORD) begin
      trap_op = CSR_MRET;
    end else begin
      trap_op = CSR_NONE;
    end
  end

  always_comb begin
    ctrl_o.bpu_op = BPU_NONE;
    ctrl_o.csr_op = trap_op;
    ctrl_o.imm    = '0;
    case (opcode)
      OPC_BRANCH: begin
        if (cond_op != BPU_NONE) begin
          ctrl_o.bpu_op = cond_op;
          ctrl_o.imm    = imm_btype;
        end
      end
      OPC_JAL: begin
        ctrl_o.bpu_op = BPU_JAL;
        ctrl_o.imm    = imm_jtype;
      end
      OPC_JALR: begin
        if (funct3 == 3'b000) begin
          ctrl_o.bpu_op = BPU_JALR;
          ctrl_o.imm    = imm_itype;
        end
      end
      default: ;
    endcase
  end

  // A jump and a trap must never be decoded from the same word.
  always_comb begin
    assert (!((ctrl_o.bpu_op != BPU_NONE) && (ctrl_o.csr_op != CSR_NONE)))
      else $error("branch_decode: bpu_op and csr_op both active for %h", instr_i);
  end

endmodule

// File: hw/branch_compare.sv
`timescale 1ns/1ps
`include "bpu_macros.svh"

module branch_compare (
  input  bpu_pkg::xlen_t      rdata1_i,
  input  bpu_pkg::xlen_t      rdata2_i,
  output bpu_pkg::cmp_flags_t flags_o
);

  import bpu_pkg::*;

  localparam int MSB = `BPU_XLEN - 1;

  xlen_t diff;
  logic  carry;
  logic  zero_f;
  logic  sign_f;
  logic  ovf_f;
  logic  borrow_f;

  // rdata1 - rdata2 as rdata1 + ~rdata2 + 1.
  assign {carry, diff} = {1'b0, rdata1_i} + {1'b0, ~rdata2_i}
                       + {{`BPU_XLEN{1'b0}}, 1'b1};

  // Overflow when operand signs differ and the result sign follows rdata2.
  assign ovf_f = (rdata1_i[MSB] & ~rdata2_i[MSB] & ~diff[MSB]) |
                 (~rdata1_i[MSB] & rdata2_i[MSB] & diff[MSB]);

  assign zero_f   = ~(|diff);
  assign sign_f   = diff[MSB];
  assign borrow_f = ~carry;  // No carry out means rdata1 < rdata2.

  assign flags_o.eq  = zero_f;
  assign flags_o.lt  = sign_f ^ ovf_f;
  assign flags_o.ltu = borrow_f;

  // Equal operands are never less than each other.
  always_comb begin
    assert (!(flags_o.eq && (flags_o.lt || flags_o.ltu)))
      else $error("branch_compare: eq with lt or ltu for %h, %h", rdata1_i, rdata2_i);
  end

endmodule

// File: hw/target_gen.sv
`timescale 1ns/1ps
`include "bpu_macros.svh"

module target_gen (
  input  bpu_pkg::addr_t    pc_i,
  input  bpu_pkg::xlen_t    rdata1_i,
  input  bpu_pkg::xlen_t    imm_i,
  output bpu_pkg::targets_t targets_o
);

  import bpu_pkg::*;

  addr_t pc_sum;
  addr_t reg_sum;
  addr_t seq_sum;

  // All three adders run in parallel with the comparator.
  assign pc_sum  = pc_i + imm_i;
  assign reg_sum = rdata1_i + imm_i;
  assign seq_sum = pc_i + `BPU_INSTR_STEP;

  assign targets_o.pc_rel  = pc_sum;
  assign targets_o.reg_rel = {reg_sum[`BPU_XLEN-1:1], 1'b0};  // JALR drops bit 0.
  assign targets_o.seq     = seq_sum;

endmodule

// File: hw/next_pc_unit.sv
`timescale 1ns/1ps
`include "bpu_macros.svh"

module next_pc_unit (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                step_i,
  input  bpu_pkg::bpu_op_e    bpu_op_i,
  input  bpu_pkg::csr_op_e    csr_op_i,
  input  bpu_pkg::cmp_flags_t flags_i,
  input  bpu_pkg::targets_t   targets_i,
  input  bpu_pkg::xlen_t      csr_rdata_i,
  output logic                branch_en_o,
  output bpu_pkg::addr_t      dnpc_o,
  output bpu_pkg::addr_t      pc_o
);

  import bpu_pkg::*;

  logic  cond_hit;
  logic  jump;
  logic  trap;
  addr_t pc_q;

  // Conditional branch outcome.
  always_comb begin
    case (bpu_op_i)
      BPU_BEQ:  cond_hit = flags_i.eq;
      BPU_BNE:  cond_hit = ~flags_i.eq;
      BPU_BLT:  cond_hit = flags_i.lt;
      BPU_BGE:  cond_hit = ~flags_i.lt;
      BPU_BLTU: cond_hit = flags_i.ltu;
      BPU_BGEU: cond_hit = ~flags_i.ltu;
      default:  cond_hit = 1'b0;
    endcase
  end

  assign jump = (bpu_op_i == BPU_JAL) || (bpu_op_i == BPU_JALR);
  assign trap = (csr_op_i == CSR_ECALL) || (csr_op_i == CSR_MRET);

  assign branch_en_o = ~rst_i & (cond_hit | jump | trap);

  always_comb begin
    if (rst_i) begin
      dnpc_o = `BPU_RESET_VECTOR;
    end else if (trap) begin
      dnpc_o = csr_rdata_i;  // Trap vector or return address.
    end else if (bpu_op_i == BPU_JALR) begin
      dnpc_o = targets_i.reg_rel;
    end else if (branch_en_o) begin
      dnpc_o = targets_i.pc_rel;  // Taken branch or JAL.
    end else begin
      dnpc_o = targets_i.seq;
    end
  end

  // Program counter, advances only on the step strobe.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pc_q <= `BPU_RESET_VECTOR;
    end else if (step_i) begin
      pc_q <= dnpc_o;
    end
  end

  assign pc_o = pc_q;

  a_no_branch_in_reset : assert property (@(posedge clk_i) rst_i |-> !branch_en_o)
    else $error("next_pc_unit: branch_en_o high during reset");

  // Holds only while the CSR side supplies aligned vectors.
  a_dnpc_aligned : assert property (@(posedge clk_i) disable iff (rst_i) !dnpc_o[0])
    else $error("next_pc_unit: dnpc_o %h is odd", dnpc_o);

endmodule

// File: hw/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            step_i,
  input  bpu_pkg::instr_t instr_i,
  input  bpu_pkg::xlen_t  rdata1_i,
  input  bpu_pkg::xlen_t  rdata2_i,
  input  bpu_pkg::xlen_t  csr_rdata_i,
  output logic            branch_en_o,
  output bpu_pkg::addr_t  dnpc_o,
  output bpu_pkg::addr_t  pc_o
);

  import bpu_pkg::*;

  branch_ctrl_t ctrl;
  cmp_flags_t   flags;
  targets_t     targets;

  branch_decode u_decode (
    .instr_i (instr_i),
    .ctrl_o  (ctrl)
  );

  branch_compare u_compare (
    .rdata1_i (rdata1_i),
    .rdata2_i (rdata2_i),
    .flags_o  (flags)
  );

  // Candidates are built from the registered PC.
  target_gen u_targets (
    .pc_i      (pc_o),
    .rdata1_i  (rdata1_i),
    .imm_i     (ctrl.imm),
    .targets_o (targets)
  );

  next_pc_unit u_next_pc (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .step_i      (step_i),
    .bpu_op_i    (ctrl.bpu_op),
    .csr_op_i    (ctrl.csr_op),
    .flags_i     (flags),
    .targets_i   (targets),
    .csr_rdata_i (csr_rdata_i),
    .branch_en_o (branch_en_o),
    .dnpc_o      (dnpc_o),
    .pc_o        (pc_o)
  );

endmodule

// File: test/tb_branch_unit.sv
`timescale 1ns/1ps
`include "bpu_macros.svh"

module tb_branch_unit;

  localparam logic [6:0]  OP_BRANCH  = 7'b1100011;
  localparam logic [6:0]  OP_JAL     = 7'b1101111;
  localparam logic [6:0]  OP_JALR    = 7'b1100111;
  localparam logic [31:0] NOP_WORD   = 32'h0000_0013;
  localparam logic [31:0] ECALL_WORD = 32'h0000_0073;
  localparam logic [31:0] MRET_WORD  = 32'h3020_0073;
  localparam logic [31:0] RESET_PC   = `BPU_RESET_VECTOR;
  localparam logic [31:0] STEP       = 32'd4;

  logic        clk_i;
  logic        rst_i;
  logic        step_i;
  logic [31:0] instr_i;
  logic [31:0] rdata1_i;
  logic [31:0] rdata2_i;
  logic [31:0] csr_rdata_i;
  logic        branch_en_o;
  logic [31:0] dnpc_o;
  logic [31:0] pc_o;

  logic        exp_en;
  logic [31:0] exp_dnpc;
  logic [31:0] model_pc;  // Expected value of pc_o.
  logic        pc_chk_en;
  logic        step_on;
  integer      seed;
  integer      errors;

  logic [2:0]  conds [6]  = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
  logic [31:0] edge_a [5] = '{32'h1234_5678, 32'h8000_0000, 32'h7fff_ffff, 32'h0, 32'hffff_ffff};
  logic [31:0] edge_b [5] = '{32'h1234_5678, 32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff, 32'h0};

  branch_unit dut_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .step_i      (step_i),
    .instr_i     (instr_i),
    .rdata1_i    (rdata1_i),
    .rdata2_i    (rdata2_i),
    .csr_rdata_i (csr_rdata_i),
    .branch_en_o (branch_en_o),
    .dnpc_o      (dnpc_o),
    .pc_o        (pc_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic log_mismatch(input string name, input logic [31:0] expv,
                              input logic [31:0] actv);
    errors++;
    $display("Error at %0t ns: %s expected %h, got %h", $time, name, expv, actv);
  endtask

  task automatic note_failure(input string msg);
    errors++;
    $display("%s (at %0t ns)", msg, $time);
  endtask

  a_branch_en : assert property (@(posedge clk_i) branch_en_o == exp_en)
    else log_mismatch("branch_en_o", {31'd0, exp_en}, {31'd0, $sampled(branch_en_o)});

  a_dnpc : assert property (@(posedge clk_i) dnpc_o == exp_dnpc)
    else log_mismatch("dnpc_o", exp_dnpc, $sampled(dnpc_o));

  a_pc_model : assert property (@(posedge clk_i) disable iff (!pc_chk_en) pc_o == model_pc)
    else log_mismatch("pc_o", model_pc, $sampled(pc_o));

  // One cycle from the strobe to the new PC.
  a_pc_step : assert property (@(posedge clk_i) disable iff (rst_i)
    step_i |=> pc_o == $past(exp_dnpc))
    else log_mismatch("pc_o", model_pc, $sampled(pc_o));

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    logic t;
    case (f3)
      3'b000:  t = (a == b);
      3'b001:  t = (a != b);
      3'b100:  t = ($signed(a) < $signed(b));
      3'b101:  t = ($signed(a) >= $signed(b));
      3'b110:  t = (a < b);
      3'b111:  t = (a >= b);
      default: t = 1'b0;
    endcase
    return t;
  endfunction

  // Falling edge. Retire the last step into the model and pick the next strobe.
  task automatic next_cycle();
    logic [31:0] rnd;
    @(negedge clk_i);
    if (step_i) begin
      model_pc = exp_dnpc;
    end
    rnd = $random(seed);
    step_i = step_on & rnd[0];
    rdata2_i = $random(seed);
    csr_rdata_i = 32'h0;
  endtask

  task automatic branch_cycle(input logic [2:0] f3, input logic [31:0] a,
                              input logic [31:0] b, input logic [12:0] imm);
    next_cycle();
    instr_i  = {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], OP_BRANCH};
    rdata1_i = a;
    rdata2_i = b;
    exp_en   = branch_taken(f3, a, b);
    exp_dnpc = exp_en ? model_pc + {{19{imm[12]}}, imm} : model_pc + STEP;
  endtask

  task automatic jal_cycle(input logic [20:0] imm);
    next_cycle();
    instr_i  = {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, OP_JAL};
    rdata1_i = $random(seed);
    exp_en   = 1'b1;
    exp_dnpc = model_pc + {{11{imm[20]}}, imm};
  endtask

  task automatic jalr_cycle(input logic [31:0] r1, input logic [11:0] imm);
    logic [31:0] sum;
    next_cycle();
    instr_i  = {imm, 5'd1, 3'b000, 5'd1, OP_JALR};
    rdata1_i = r1;
    sum      = r1 + {{20{imm[11]}}, imm};
    exp_en   = 1'b1;
    exp_dnpc = {sum[31:1], 1'b0};  // Bit 0 cleared.
  endtask

  task automatic trap_cycle(input logic [31:0] word, input logic [31:0] csr);
    next_cycle();
    instr_i     = word;
    rdata1_i    = $random(seed);
    csr_rdata_i = csr;
    exp_en      = 1'b1;
    exp_dnpc    = csr;
  endtask

  task automatic plain_cycle(input logic [31:0] word);
    next_cycle();
    instr_i  = word;
    rdata1_i = $random(seed);
    exp_en   = 1'b0;
    exp_dnpc = model_pc + STEP;
  endtask

  task automatic wait_pc_reset(input int max_cycles);
    int n;
    n = 0;
    while (pc_o !== RESET_PC && n < max_cycles) begin
      @(negedge clk_i);
      n++;
    end
    if (pc_o !== RESET_PC) begin
      note_failure("Timeout waiting for pc_o to reach the reset vector");
    end
  endtask

  initial begin
    logic [31:0] rnd;
    logic [31:0] a;
    logic [31:0] b;
    logic [6:0]  opc;
    seed        = 21;
    errors      = 0;
    rst_i       = 1'b1;
    step_i      = 1'b0;
    instr_i     = ECALL_WORD;  // A trap word that reset must mask.
    rdata1_i    = 32'h0;
    rdata2_i    = 32'h0;
    csr_rdata_i = 32'h0;
    exp_en      = 1'b0;
    exp_dnpc    = RESET_PC;
    model_pc    = RESET_PC;
    pc_chk_en   = 1'b0;
    step_on     = 1'b1;

    @(posedge clk_i);
    @(negedge clk_i);
    pc_chk_en = 1'b1;  // PC is defined after the first reset edge.
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_i    = 1'b0;
    instr_i  = NOP_WORD;
    exp_dnpc = model_pc + STEP;
    wait_pc_reset(10);

    foreach (conds[i]) begin
      foreach (edge_a[j]) begin
        rnd = $random(seed);
        branch_cycle(conds[i], edge_a[j], edge_b[j], {rnd[12:1], 1'b0});
      end
      repeat (20) begin
        a   = $random(seed);
        b   = $random(seed);
        rnd = $random(seed);
        if (rnd[14:13] == 2'b00) begin
          b = a;
        end
        branch_cycle(conds[i], a, b, {rnd[12:1], 1'b0});
      end
    end

    repeat (10) begin
      rnd = $random(seed);
      jal_cycle({rnd[20:1], 1'b0});
    end
    jalr_cycle(32'h0000_1000, 12'h001);  // Odd sum.
    repeat (10) begin
      a   = $random(seed);
      rnd = $random(seed);
      jalr_cycle(a, rnd[11:0]);
    end

    rnd = $random(seed);
    trap_cycle(ECALL_WORD, {rnd[31:2], 2'b00});
    rnd = $random(seed);
    trap_cycle(MRET_WORD, {rnd[31:2], 2'b00});

    repeat (20) begin
      rnd = $random(seed);
      case (rnd[1:0])
        2'b00:   opc = 7'b0110011;
        2'b01:   opc = 7'b0010011;
        default: opc = 7'b0000011;
      endcase
      plain_cycle({rnd[31:7], opc});
    end

    // PC must hold with the strobe low.
    step_on = 1'b0;
    repeat (6) plain_cycle(NOP_WORD);
    branch_cycle(3'b000, 32'h5, 32'h5, 13'h010);
    plain_cycle(NOP_WORD);

    @(posedge clk_i);
    @(negedge clk_i);
    $display("Run complete, %0d errors", errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: sim.f
+incdir+hw
hw/bpu_pkg.sv
hw/branch_decode.sv
hw/branch_compare.sv
hw/target_gen.sv
hw/next_pc_unit.sv
hw/branch_unit.sv
test/tb_branch_unit.sv

// File: Makefile
.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module tb_branch_unit
	verilator --lint-only -f sim.f hw/branch_unit.sv --top-module branch_unit

obj_dir/tb_branch_unit: sim.f hw/bpu_macros.svh hw/*.sv test/tb_branch_unit.sv
	verilator --binary --timing --assert -f sim.f --top-module tb_branch_unit \
		-Mdir obj_dir -o tb_branch_unit

sim: obj_dir/tb_branch_unit
	./obj_dir/tb_branch_unit > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "ERRORS FOUND" sim.log; then \
		echo "Simulation failed, see sim.log"; exit 1; \
	fi
	@if ! grep -q "NO ERRORS" sim.log; then \
		echo "Simulation ended early, see sim.log"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
